// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Datapath word and register index
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // Instruction families, top two bits
    typedef enum logic [1:0] {
        OP_R = 2'b00,
        OP_M = 2'b01,
        OP_J = 2'b10,
        OP_X = 2'b11
    } opcode_e;

    // R-family mod codes
    localparam logic [5:0] MOD_MOV  = 6'd0;
    localparam logic [5:0] MOD_ADD  = 6'd1;
    localparam logic [5:0] MOD_XOR  = 6'd5;
    localparam logic [5:0] MOD_ADDI = 6'd16;
    // M-family mod codes
    localparam logic [5:0] MOD_PUSH = 6'd2;
    localparam logic [5:0] MOD_POP  = 6'd3;

    // [Op:2][Mod:6][Src:4][Dst:4], high byte arrives first
    typedef struct packed {
        opcode_e    op;
        logic [5:0] mod;
        reg_idx_t   src;
        reg_idx_t   dst;
    } instr_t;

    // Register write source
    typedef enum logic [2:0] {
        ALU_MOV,
        ALU_ADD,
        ALU_XOR,
        ALU_ADDI,
        ALU_LOAD
    } alu_op_e;

    // Register shown at the outputs
    localparam reg_idx_t DISPLAY_REG = 4'd3;

    // Serial line timing
    localparam int CLK_FREQ_HZ    = 100_000_000;
    localparam int BAUD_RATE      = 115_200;
    localparam int CYCLES_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    localparam int HALF_BIT       = CYCLES_PER_BIT / 2;

endpackage

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Word-addressed stack memory
    localparam int STACK_AW    = 6;
    typedef logic [STACK_AW-1:0] stack_addr_t;
    localparam int STACK_DEPTH = 2 ** STACK_AW;

    // Start-up fill of the low area
    localparam int          INIT_WORDS   = 32;
    localparam logic [15:0] INIT_PATTERN = 16'hA301;

    // First free word above the filled base
    localparam stack_addr_t SP_START = 6'd8;

    // Request to data strobe, in cycles
    localparam int MEM_LATENCY = 3;

endpackage

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if
    import cpu_pkg::*, mem_pkg::*;
();
    // Write channel
    logic        wr_req;
    stack_addr_t wr_addr;
    word_t       wr_data;
    logic        wr_data_req;
    logic        wr_finish;

    // Read channel
    logic        rd_req;
    stack_addr_t rd_addr;
    word_t       rd_data;
    logic        rd_valid;
    logic        rd_finish;

    // Requests are levels held until finish
    modport requester (
        output wr_req, wr_addr, wr_data, rd_req, rd_addr,
        input  wr_data_req, wr_finish, rd_data, rd_valid, rd_finish
    );

    modport memory (
        input  wr_req, wr_addr, wr_data, rd_req, rd_addr,
        output wr_data_req, wr_finish, rd_data, rd_valid, rd_finish
    );

endinterface

`default_nettype wire

// ==== logic/baud_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_timer
    import cpu_pkg::*;
(
    input  logic clk_100mhz,
    input  logic rst_n,
    input  logic restart,
    input  logic half_sel,
    output logic tick
);
    typedef logic [$clog2(CYCLES_PER_BIT)-1:0] cnt_t;

    cnt_t cnt;
    cnt_t last;

    // Terminal count for half or full bit
    assign last = half_sel ? cnt_t'(HALF_BIT - 1) : cnt_t'(CYCLES_PER_BIT - 1);

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (restart) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == last) begin
            // Wrap and flag one period
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // Ticks are always at least a half bit apart
    assert property (@(posedge clk_100mhz) disable iff (!rst_n) tick |=> !tick);

endmodule

`default_nettype wire

// ==== logic/uart_byte_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e  state;
    logic       rx_meta;
    logic       rx_sync;
    logic [2:0] bit_cnt;
    logic       restart;
    logic       half_sel;
    logic       tick;

    // Timer held clear while idle, half bit for start check
    assign restart  = (state == RX_IDLE);
    assign half_sel = (state == RX_START);

    baud_timer u_baud_timer (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .restart    (restart),
        .half_sel   (half_sel),
        .tick       (tick)
    );

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Falling edge starts a frame
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        // Still low mid-bit, else it was a glitch
                        if (rx_sync) begin
                            state <= RX_IDLE;
                        end else begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // Framing error drops the byte
                    if (tick) begin
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, sampled mid-bit
    always_ff @(posedge clk_100mhz) begin
        if (state == RX_DATA && tick) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    // One pulse per frame
    assert property (@(posedge clk_100mhz) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== logic/exec_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_fsm
    import cpu_pkg::*, mem_pkg::*;
(
    input  logic          clk_100mhz,
    input  logic          rst_n,
    input  logic [7:0]    rx_byte,
    input  logic          rx_valid,
    output logic          cmd_ready,
    output logic          wr_en,
    output alu_op_e       alu_op,
    output reg_idx_t      dst,
    output reg_idx_t      src,
    output logic [3:0]    imm,
    output word_t         load_data,
    input  word_t         dst_value,
    mem_port_if.requester mem
);
    typedef enum logic [2:0] {
        INIT_FILL,
        INIT_FILL_WAIT,
        INIT_READ,
        INIT_READ_WAIT,
        FETCH,
        PUSH_WAIT,
        POP_WAIT
    } state_e;

    state_e      state;
    stack_addr_t fill_cnt;
    stack_addr_t sp;
    logic [7:0]  high_byte;
    logic        have_high;
    instr_t      instr;
    logic        issue;
    logic        r_valid;
    alu_op_e     r_op;

    // Low byte completes the instruction
    assign instr     = instr_t'({high_byte, rx_byte});
    assign issue     = (state == FETCH) && rx_valid && have_high;
    assign cmd_ready = (state == FETCH);

    // Fill pattern at start-up, pushed register afterwards
    assign mem.wr_data = (state == PUSH_WAIT) ? dst_value : INIT_PATTERN;

    // R-family decode
    always_comb begin
        r_valid = 1'b1;
        case (instr.mod)
            MOD_MOV:  r_op = ALU_MOV;
            MOD_ADD:  r_op = ALU_ADD;
            MOD_XOR:  r_op = ALU_XOR;
            MOD_ADDI: r_op = ALU_ADDI;
            default: begin
                r_op    = ALU_MOV;
                r_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state      <= INIT_FILL;
            fill_cnt   <= '0;
            sp         <= SP_START;
            have_high  <= 1'b0;
            wr_en      <= 1'b0;
            alu_op     <= ALU_MOV;
            mem.wr_req <= 1'b0;
            mem.rd_req <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                INIT_FILL: begin
                    if (fill_cnt == stack_addr_t'(INIT_WORDS)) begin
                        state <= INIT_READ;
                    end else begin
                        mem.wr_req <= 1'b1;
                        state      <= INIT_FILL_WAIT;
                    end
                end
                INIT_FILL_WAIT: begin
                    if (mem.wr_data_req) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (mem.wr_finish) begin
                        mem.wr_req <= 1'b0;
                        state      <= INIT_FILL;
                    end
                end
                INIT_READ: begin
                    // Word 0 back into the display register
                    mem.rd_req <= 1'b1;
                    state      <= INIT_READ_WAIT;
                end
                INIT_READ_WAIT, POP_WAIT: begin
                    // Data registered into load_data, written next cycle
                    if (mem.rd_valid) begin
                        wr_en  <= 1'b1;
                        alu_op <= ALU_LOAD;
                    end
                    if (mem.rd_finish) begin
                        mem.rd_req <= 1'b0;
                        state      <= FETCH;
                    end
                end
                FETCH: begin
                    if (rx_valid) begin
                        have_high <= !have_high;
                    end
                    if (issue) begin
                        case (instr.op)
                            OP_R: begin
                                wr_en  <= r_valid;
                                alu_op <= r_op;
                            end
                            OP_M: begin
                                if (instr.mod == MOD_PUSH) begin
                                    mem.wr_req <= 1'b1;
                                    state      <= PUSH_WAIT;
                                end else if (instr.mod == MOD_POP) begin
                                    sp         <= sp - 1'b1;
                                    mem.rd_req <= 1'b1;
                                    state      <= POP_WAIT;
                                end
                            end
                            // J and X families do nothing
                            default: ;
                        endcase
                    end
                end
                PUSH_WAIT: begin
                    // Post-increment once the word is taken
                    if (mem.wr_data_req) begin
                        sp <= sp + 1'b1;
                    end
                    if (mem.wr_finish) begin
                        mem.wr_req <= 1'b0;
                        state      <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // Operand fields and addresses
    always_ff @(posedge clk_100mhz) begin
        if (state == FETCH && rx_valid && !have_high) begin
            high_byte <= rx_byte;
        end
        if (issue) begin
            dst <= instr.dst;
            src <= instr.src;
            imm <= instr.src;
        end else if (state == INIT_READ) begin
            dst <= DISPLAY_REG;
        end
        if (mem.rd_valid) begin
            load_data <= mem.rd_data;
        end
        if (state == INIT_FILL) begin
            mem.wr_addr <= fill_cnt;
        end else if (issue) begin
            mem.wr_addr <= sp;
        end
        // POP reads below the current pointer
        if (state == INIT_READ) begin
            mem.rd_addr <= '0;
        end else if (issue) begin
            mem.rd_addr <= sp - 1'b1;
        end
    end

    // One transaction at a time on the shared port
    assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        !(mem.wr_req && mem.rd_req));

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       wr_en,
    input  alu_op_e    alu_op,
    input  reg_idx_t   dst,
    input  reg_idx_t   src,
    input  logic [3:0] imm,
    input  word_t      load_data,
    output word_t      dst_value,
    output word_t      disp_value
);
    word_t regs [16];
    word_t src_value;
    word_t result;

    // Asynchronous read ports
    assign dst_value  = regs[dst];
    assign src_value  = regs[src];
    assign disp_value = regs[DISPLAY_REG];

    // Two-operand ALU, dst is also the left operand
    always_comb begin
        case (alu_op)
            ALU_MOV:  result = src_value;
            ALU_ADD:  result = dst_value + src_value;
            ALU_XOR:  result = dst_value ^ src_value;
            ALU_ADDI: result = dst_value + {12'h000, imm};
            ALU_LOAD: result = load_data;
            default:  result = src_value;
        endcase
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dst] <= result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/stack_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_ram
    import cpu_pkg::*, mem_pkg::*;
(
    input  logic       clk_100mhz,
    input  logic       rst_n,
    mem_port_if.memory mem
);
    typedef logic [$clog2(MEM_LATENCY + 2)-1:0] lat_cnt_t;

    word_t    ram [STACK_DEPTH];
    logic     busy;
    logic     is_wr;
    lat_cnt_t lat_cnt;
    logic     strobe;
    logic     finish;

    // Data strobe at MEM_LATENCY and finish one cycle later
    assign strobe = busy && (lat_cnt == lat_cnt_t'(MEM_LATENCY));
    assign finish = busy && (lat_cnt == lat_cnt_t'(MEM_LATENCY + 1));

    assign mem.wr_data_req = strobe && is_wr;
    assign mem.wr_finish   = finish && is_wr;
    assign mem.rd_valid    = strobe && !is_wr;
    assign mem.rd_finish   = finish && !is_wr;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            is_wr   <= 1'b0;
            lat_cnt <= '0;
        end else if (!busy) begin
            // Accept a new request once the last one has dropped
            if (mem.wr_req || mem.rd_req) begin
                busy    <= 1'b1;
                is_wr   <= mem.wr_req;
                lat_cnt <= lat_cnt_t'(1);
            end
        end else if (finish) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // Synchronous read and write on strobe
    always_ff @(posedge clk_100mhz) begin
        if (mem.wr_data_req) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
        mem.rd_data <= ram[mem.rd_addr];
    end

    // Requester holds its level through finish
    assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        busy |-> (is_wr ? mem.wr_req : mem.rd_req));

    // Address held for the whole transaction
    assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        busy |-> (is_wr ? $stable(mem.wr_addr) : $stable(mem.rd_addr)));

endmodule

`default_nettype wire

// ==== logic/uart_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cpu_top
    import cpu_pkg::*;
(
    input  logic  clk_100mhz,
    input  logic  rst_n,
    input  logic  uart_rx,
    output logic  cmd_ready,
    output word_t disp_value
);
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       wr_en;
    alu_op_e    alu_op;
    reg_idx_t   dst;
    reg_idx_t   src;
    logic [3:0] imm;
    word_t      load_data;
    word_t      dst_value;

    // Stack memory port
    mem_port_if u_mem_port ();

    uart_byte_rx u_uart_byte_rx (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid)
    );

    exec_fsm u_exec_fsm (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .cmd_ready  (cmd_ready),
        .wr_en      (wr_en),
        .alu_op     (alu_op),
        .dst        (dst),
        .src        (src),
        .imm        (imm),
        .load_data  (load_data),
        .dst_value  (dst_value),
        .mem        (u_mem_port.requester)
    );

    // r3 comes out as disp_value
    reg_file u_reg_file (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .alu_op     (alu_op),
        .dst        (dst),
        .src        (src),
        .imm        (imm),
        .load_data  (load_data),
        .dst_value  (dst_value),
        .disp_value (disp_value)
    );

    stack_ram u_stack_ram (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .mem        (u_mem_port.memory)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_100mhz,
    output logic rst_n
);
    // 10 ns period
    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    // Reset low for ten rising edges and released on an edge
    initial begin
        rst_n <= 1'b0;
        repeat (10) @(posedge clk_100mhz);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/uart_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cpu_tb
    import cpu_pkg::*, mem_pkg::*;
();
    // One instruction and the r3 it should leave behind
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
        word_t      exp_r3;
    } step_t;

    localparam int NUM_STEPS = 21;

    // Start-up bound of reset and 33 memory transactions
    localparam int STARTUP_CYCLES  = 10 + (INIT_WORDS + 1) * (MEM_LATENCY + 5);
    // Two 10-bit frames plus the longest idle gap
    localparam int ROW_CYCLES      = (2 * 10 + 15) * CYCLES_PER_BIT;
    localparam int WATCHDOG_CYCLES = 2 * STARTUP_CYCLES + NUM_STEPS * ROW_CYCLES;

    logic        clk_100mhz;
    logic        rst_n;
    logic        uart_rx;
    logic        cmd_ready;
    word_t       disp_value;
    logic [31:0] rng;

    // High byte is {op, mod} and low byte is {src, dst}
    // Start state has r3 = A301, other registers 0 and sp = 8
    step_t steps [NUM_STEPS] = '{
        '{8'h10, 8'h91, 16'hA301},  // ADDI r1, 9   -> r1 = 0009
        '{8'h10, 8'hF1, 16'hA301},  // ADDI r1, 15  -> r1 = 0018
        '{8'h10, 8'h72, 16'hA301},  // ADDI r2, 7   -> r2 = 0007
        '{8'h01, 8'h21, 16'hA301},  // ADD r1 += r2 -> r1 = 001F
        '{8'h00, 8'h13, 16'h001F},  // MOV r3 <- r1
        '{8'h05, 8'h23, 16'h0018},  // XOR r3 ^= r2
        // Two nested pushes then unwind
        '{8'h42, 8'h03, 16'h0018},  // PUSH r3 into word 8
        '{8'h00, 8'h13, 16'h001F},  // MOV r3 <- r1
        '{8'h42, 8'h03, 16'h001F},  // PUSH r3 into word 9
        '{8'h10, 8'h53, 16'h0024},  // ADDI r3, 5
        '{8'h43, 8'h03, 16'h001F},  // POP r3 from word 9
        '{8'h43, 8'h03, 16'h0018},  // POP r3 from word 8
        // Below the start pointer lies the fill pattern
        '{8'h43, 8'h03, 16'hA301},  // POP r3 from word 7
        '{8'h01, 8'h33, 16'h4602},  // ADD r3 += r3 with wraparound
        // Ignored codes
        '{8'h07, 8'h13, 16'h4602},  // R-family mod 7
        '{8'h44, 8'h03, 16'h4602},  // M-family mod 4
        '{8'h80, 8'h13, 16'h4602},  // Unused family 2
        '{8'hD0, 8'hF3, 16'h4602},  // Unused family 3
        // Pairing must still be aligned here
        '{8'h10, 8'h13, 16'h4603},  // ADDI r3, 1
        '{8'h05, 8'h13, 16'h461C},  // XOR r3 ^= r1
        '{8'h00, 8'h23, 16'h0007}   // MOV r3 <- r2
    };

    tb_clock_gen u_tb_clock_gen (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n)
    );

    uart_cpu_top u_uart_cpu_top (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .cmd_ready  (cmd_ready),
        .disp_value (disp_value)
    );

    // 32-bit LCG with upper bits for the gap
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first wrong word");
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first wrong level");
        end
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk_100mhz);
            uart_rx <= frame[b];
            repeat (CYCLES_PER_BIT - 1) @(posedge clk_100mhz);
        end
    endtask

    // Sampled away from the rising edge
    task automatic wait_cmd_ready();
        @(negedge clk_100mhz);
        while (cmd_ready !== 1'b1) begin
            @(negedge clk_100mhz);
        end
    endtask

    initial begin
        int gap;
        uart_rx <= 1'b1;
        rng     = 32'd4;
        // Low through reset and at the first edge after release
        while (rst_n !== 1'b1) begin
            @(negedge clk_100mhz);
            check_level(cmd_ready, 1'b0, "cmd_ready during or right after reset");
        end
        wait_cmd_ready();
        check_word(disp_value, 16'hA301, "r3 after start-up read-back");
        for (int i = 0; i < NUM_STEPS; i++) begin
            rng = lcg_next(rng);
            gap = int'(rng[19:16]);
            // Line idles high between instructions
            repeat (gap * CYCLES_PER_BIT) @(posedge clk_100mhz);
            send_byte(steps[i].hi);
            send_byte(steps[i].lo);
            wait_cmd_ready();
            check_word(disp_value, steps[i].exp_r3, $sformatf("r3 after step %0d", i));
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout: the stimulus table did not finish within %0d cycles", WATCHDOG_CYCLES);
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/cpu_pkg.sv
logic/mem_pkg.sv
logic/mem_port_if.sv
logic/baud_timer.sv
logic/uart_byte_rx.sv
logic/exec_fsm.sv
logic/reg_file.sv
logic/stack_ram.sv
logic/uart_cpu_top.sv
sim/tb_clock_gen.sv
sim/uart_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART CPU testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module uart_cpu_tb -f list.f -o uart_cpu_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uart_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with exit status $status"
    exit "$status"
fi
exit 0
